// ==== src/pu_spi_pkg.sv ====
`default_nettype none

package pu_spi_pkg;

    // core data path widths
    localparam int data_width = 32;
    localparam int attr_width = 4;

    // words per ping-pong half
    localparam int buf_size = 6;

    // one buffered core word with its tag
    typedef struct packed {
        logic [data_width-1:0] data;
        logic [attr_width-1:0] attr;
    } pu_word_t;

endpackage

`default_nettype wire

// ==== src/spi_link_pkg.sv ====
`default_nettype none

package spi_link_pkg;

    localparam int spi_byte_width = 8;

    // bytes sent msb first for each core data word
    localparam int bytes_per_word = 4;

    // cycles a pin level must hold before it is accepted
    localparam int filter_len = 8;

    typedef logic [spi_byte_width-1:0] spi_byte_t;

    // spi pins as seen by the slave
    typedef struct packed {
        logic cs;
        logic sclk;
        logic mosi;
    } spi_pins_t;

endpackage

`default_nettype wire

// ==== src/bounce_filter.sv ====
`default_nettype none

module bounce_filter #(
    parameter logic init = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic din,
    output logic dout
);

    import spi_link_pkg::*;

    logic [$clog2(filter_len + 1)-1:0] cnt;

    // count how long din has disagreed with dout
    // any return to the old level starts over
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            dout <= init;
        end else if (din == dout) begin
            cnt <= '0;
        end else if (int'(cnt) == filter_len) begin
            cnt  <= '0;
            dout <= din;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/send_buffer.sv ====
`default_nettype none

module send_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 wr,
    input  pu_spi_pkg::pu_word_t wdata,
    input  logic                 pop,
    output pu_spi_pkg::pu_word_t rdata,
    output logic                 valid
);

    import pu_spi_pkg::*;

    pu_word_t mem [buf_size];

    logic [$clog2(buf_size)-1:0]   wr_ptr;
    logic [$clog2(buf_size)-1:0]   rd_ptr;
    logic [$clog2(buf_size+1)-1:0] count;
    logic                          do_wr;
    logic                          do_pop;

    // overflow writes are dropped
    assign do_wr  = wr && (int'(count) < buf_size);
    assign do_pop = pop && valid;

    assign valid = count != '0;
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (int'(wr_ptr) == buf_size - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (int'(rd_ptr) == buf_size - 1) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + do_wr - do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr && !clear) begin
            mem[wr_ptr] <= wdata;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst || clear)
        wr |-> int'(count) < buf_size);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst || clear)
        pop |-> count != '0);

endmodule

`default_nettype wire

// ==== src/word_splitter.sv ====
`default_nettype none

module word_splitter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear,
    input  pu_spi_pkg::pu_word_t    word,
    input  logic                    word_valid,
    output logic                    pop,
    output spi_link_pkg::spi_byte_t byte_out,
    output logic                    byte_valid,
    input  logic                    take
);

    import pu_spi_pkg::*;
    import spi_link_pkg::*;

    logic [data_width-1:0]             data_q;
    logic                              loaded;
    logic [$clog2(bytes_per_word)-1:0] idx;
    logic                              last_byte;

    assign last_byte = int'(idx) == bytes_per_word - 1;

    // refill when empty or when the final byte leaves
    assign pop = !clear && word_valid && (!loaded || (take && last_byte));

    assign byte_valid = loaded;

    // msb byte first
    assign byte_out =
        data_q[(bytes_per_word - 1 - int'(idx)) * spi_byte_width +: spi_byte_width];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            loaded <= 1'b0;
            idx    <= '0;
        end else if (pop) begin
            loaded <= 1'b1;
            idx    <= '0;
        end else if (take && loaded) begin
            if (last_byte) begin
                loaded <= 1'b0;
            end
            idx <= idx + 1'b1;
        end
    end

    // only data goes out on the link
    always_ff @(posedge clk) begin
        if (pop) begin
            data_q <= word.data;
        end
    end

endmodule

`default_nettype wire

// ==== src/spi_slave_shifter.sv ====
`default_nettype none

module spi_slave_shifter (
    input  logic                    clk,
    input  logic                    rst,
    input  spi_link_pkg::spi_pins_t pins,
    input  spi_link_pkg::spi_byte_t byte_in,
    input  logic                    byte_valid,
    output logic                    take,
    output logic                    miso
);

    import spi_link_pkg::*;

    logic                              cs_q;
    logic                              sclk_q;
    spi_byte_t                         shift_q;
    logic [$clog2(spi_byte_width)-1:0] bit_cnt;
    logic                              cs_fall;
    logic                              sclk_fall;
    logic                              last_bit;

    ////////////////////
    // edge detect

    assign cs_fall   = cs_q && !pins.cs;
    assign sclk_fall = sclk_q && !pins.sclk && !pins.cs;
    assign last_bit  = int'(bit_cnt) == spi_byte_width - 1;

    // load on frame start and after the eighth falling edge
    assign take = cs_fall || (sclk_fall && last_bit);

    assign miso = shift_q[spi_byte_width-1];

    ////////////////////
    // shift register

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q    <= 1'b1;
            sclk_q  <= 1'b0;
            shift_q <= '0;
            bit_cnt <= '0;
        end else begin
            cs_q   <= pins.cs;
            sclk_q <= pins.sclk;
            if (pins.cs) begin
                // idle link keeps miso low
                shift_q <= '0;
                bit_cnt <= '0;
            end else if (take) begin
                // empty splitter reads as zero
                shift_q <= byte_valid ? byte_in : '0;
                bit_cnt <= '0;
            end else if (sclk_fall) begin
                shift_q <= {shift_q[spi_byte_width-2:0], 1'b0};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    a_clean_frame_start: assert property (@(posedge clk) disable iff (rst)
        cs_fall |-> bit_cnt == '0 && !miso);

endmodule

`default_nettype wire

// ==== src/spi_frame_ctrl.sv ====
`default_nettype none

module spi_frame_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic cs,
    input  logic cycle,
    output logic sel,
    output logic stop
);

    typedef enum logic {
        st_idle,
        st_active
    } state_t;

    state_t state;
    logic   cs_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cs_q  <= 1'b1;
            sel   <= 1'b0;
            stop  <= 1'b0;
        end else begin
            cs_q <= cs;
            stop <= 1'b0;
            case (state)
                st_idle: begin
                    if (cs_q && !cs) begin
                        state <= st_active;
                    end else if (cycle && cs) begin
                        // swap ping-pong halves
                        sel <= !sel;
                    end
                end
                st_active: begin
                    // end of transaction
                    if (!cs_q && cs) begin
                        state <= st_idle;
                        stop  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_stop_pulse: assert property (@(posedge clk) disable iff (rst)
        stop |=> !stop);

endmodule

`default_nettype wire

// ==== src/pu_slave_spi.sv ====
`default_nettype none

module pu_slave_spi (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cycle,
    input  logic                              wr,
    input  logic [pu_spi_pkg::data_width-1:0] data,
    input  logic [pu_spi_pkg::attr_width-1:0] attr,
    output logic                              flag_stop,
    input  spi_link_pkg::spi_pins_t           pins,
    output logic                              miso
);

    import pu_spi_pkg::*;
    import spi_link_pkg::*;

    spi_pins_t f_pins;
    pu_word_t  wr_word;
    pu_word_t  buf_rdata [2];
    logic      buf_valid [2];
    logic      buf_wr    [2];
    logic      buf_pop   [2];
    logic      buf_clear [2];
    logic      sel;
    logic      split_pop;
    spi_byte_t split_byte;
    logic      split_valid;
    logic      take;

    ////////////////////
    // pin filters

    bounce_filter #(.init(1'b1)) u_cs_filter (
        .clk(clk), .rst(rst), .din(pins.cs), .dout(f_pins.cs)
    );

    bounce_filter u_sclk_filter (
        .clk(clk), .rst(rst), .din(pins.sclk), .dout(f_pins.sclk)
    );

    bounce_filter u_mosi_filter (
        .clk(clk), .rst(rst), .din(pins.mosi), .dout(f_pins.mosi)
    );

    ////////////////////
    // ping-pong buffers

    assign wr_word = '{data: data, attr: attr};

    // sel picks the read half and writes go to the other
    for (genvar i = 0; i < 2; i++) begin : g_buf
        assign buf_wr[i]    = wr && (sel != 1'(i));
        assign buf_pop[i]   = split_pop && (sel == 1'(i));
        assign buf_clear[i] = flag_stop && (sel == 1'(i));

        send_buffer u_send_buffer (
            .clk(clk),
            .rst(rst),
            .clear(buf_clear[i]),
            .wr(buf_wr[i]),
            .wdata(wr_word),
            .pop(buf_pop[i]),
            .rdata(buf_rdata[i]),
            .valid(buf_valid[i])
        );
    end

    ////////////////////
    // link side

    word_splitter u_word_splitter (
        .clk(clk),
        .rst(rst),
        .clear(flag_stop),
        .word(buf_rdata[sel]),
        .word_valid(buf_valid[sel]),
        .pop(split_pop),
        .byte_out(split_byte),
        .byte_valid(split_valid),
        .take(take)
    );

    spi_slave_shifter u_spi_slave_shifter (
        .clk(clk),
        .rst(rst),
        .pins(f_pins),
        .byte_in(split_byte),
        .byte_valid(split_valid),
        .take(take),
        .miso(miso)
    );

    spi_frame_ctrl u_spi_frame_ctrl (
        .clk(clk),
        .rst(rst),
        .cs(f_pins.cs),
        .cycle(cycle),
        .sel(sel),
        .stop(flag_stop)
    );

endmodule

`default_nettype wire

// ==== verif/tb_pu_slave_spi.sv ====
`default_nettype none

module tb_pu_slave_spi;

    import pu_spi_pkg::*;
    import spi_link_pkg::*;

    localparam int half_sclk  = 4 * filter_len;
    localparam int stop_limit = 4 * filter_len;
    localparam int max_cmds   = 64;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  cycle;
    logic                  wr;
    logic [data_width-1:0] data;
    logic [attr_width-1:0] attr;
    logic                  flag_stop;
    spi_pins_t             pins;
    logic                  miso;

    logic [39:0] cmds [max_cmds];
    spi_byte_t   exp_q [$];
    pu_word_t    pend_q [$];
    int          seed = 57;

    always #5 clk = ~clk;

    pu_slave_spi u_pu_slave_spi (
        .clk(clk),
        .rst(rst),
        .cycle(cycle),
        .wr(wr),
        .data(data),
        .attr(attr),
        .flag_stop(flag_stop),
        .pins(pins),
        .miso(miso)
    );

    ////////////////////
    // checks

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check_byte(input spi_byte_t got, input spi_byte_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_stop(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: flag_stop = %b, expected %b", $time, got, exp));
        end
    endtask

    task automatic check_miso(input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: miso = %b, expected %b", $time, got, exp));
        end
    endtask

    ////////////////////
    // core and link drivers

    task automatic write_word(input pu_word_t w);
        data = w.data;
        attr = w.attr;
        wr   = 1'b1;
        @(negedge clk);
        wr   = 1'b0;
    endtask

    task automatic idle_check(input int n);
        repeat (n) begin
            @(negedge clk);
            check_miso(miso, 1'b0);
            check_stop(flag_stop, 1'b0);
        end
    endtask

    // one pulse within the limit and low again after it
    task automatic wait_stop();
        int n;
        n = 0;
        while (flag_stop !== 1'b1) begin
            if (n == stop_limit) begin
                fail_run("flag_stop did not pulse after cs went high");
            end
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        check_stop(flag_stop, 1'b0);
    endtask

    // mode 0 master with one sample per bit at mid sclk high
    task automatic run_transaction(input logic glitch);
        spi_byte_t got;
        int        nbytes;
        nbytes  = exp_q.size();
        pins.cs = 1'b0;
        while (pend_q.size() > 0) begin
            write_word(pend_q.pop_front());
        end
        repeat (half_sclk) @(negedge clk);
        for (int i = 0; i < nbytes; i++) begin
            for (int b = spi_byte_width - 1; b >= 0; b--) begin
                pins.sclk = 1'b1;
                repeat (half_sclk / 2) @(negedge clk);
                got[b] = miso;
                check_stop(flag_stop, 1'b0);
                repeat (half_sclk / 2) @(negedge clk);
                pins.sclk = 1'b0;
                pins.mosi = 1'($random(seed));
                if (glitch && i == 1 && b == 4) begin
                    // short spike that must not count as an edge
                    repeat (12) @(negedge clk);
                    pins.sclk = 1'b1;
                    repeat (filter_len / 2) @(negedge clk);
                    pins.sclk = 1'b0;
                    repeat (half_sclk - 12 - filter_len / 2) @(negedge clk);
                end else begin
                    repeat (half_sclk) @(negedge clk);
                end
            end
            check_byte(got, exp_q.pop_front(), "miso byte");
        end
        pins.cs = 1'b1;
    endtask

    ////////////////////
    // command loop

    initial begin
        logic [3:0]            op;
        logic [data_width-1:0] arg;
        logic [attr_width-1:0] tag;
        pu_word_t              w;
        rst   = 1'b1;
        cycle = 1'b0;
        wr    = 1'b0;
        data  = '0;
        attr  = '0;
        pins  = '{cs: 1'b1, sclk: 1'b0, mosi: 1'b0};
        $readmemh("verif/pu_slave_spi_stimulus.txt", cmds);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int pc = 0; pc < max_cmds; pc++) begin
            {op, arg, tag} = cmds[pc];
            if (op == 4'h0 || $isunknown(op)) begin
                break;
            end
            w.data = arg;
            w.attr = tag;
            case (op)
                4'h1: write_word(w);
                4'h2: pend_q.push_back(w);
                4'h3: begin
                    cycle = 1'b1;
                    @(negedge clk);
                    cycle = 1'b0;
                end
                4'h4: begin
                    for (int k = bytes_per_word - 1; k >= 0; k--) begin
                        exp_q.push_back(arg[k*spi_byte_width +: spi_byte_width]);
                    end
                end
                4'h5: run_transaction(tag[0]);
                4'h6: wait_stop();
                4'h7: idle_check(int'(arg));
                default: fail_run($sformatf("unknown stimulus command %h at entry %0d", op, pc));
            endcase
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/pu_spi_pkg.sv
src/spi_link_pkg.sv
src/bounce_filter.sv
src/send_buffer.sv
src/word_splitter.sv
src/spi_slave_shifter.sv
src/spi_frame_ctrl.sv
src/pu_slave_spi.sv
verif/tb_pu_slave_spi.sv

// ==== Bender.yml ====
package:
  name: pu_slave_spi

sources:
  - src/pu_spi_pkg.sv
  - src/spi_link_pkg.sv
  - src/bounce_filter.sv
  - src/send_buffer.sv
  - src/word_splitter.sv
  - src/spi_slave_shifter.sv
  - src/spi_frame_ctrl.sv
  - src/pu_slave_spi.sv
  - target: test
    files:
      - verif/tb_pu_slave_spi.sv

// ==== verif/pu_slave_spi_stimulus.txt ====
// op_data_attr: 1 write, 2 write during next transaction, 3 cycle pulse, 4 expect data word
// 5 transaction over expected bytes (attr 1 adds sclk glitch), 6 expect stop, 7 idle, 0 end
7_00000040_0
1_11223344_5
1_a5c30f96_a
3_00000000_0
4_11223344_0
4_a5c30f96_0
4_00000000_0  // read past the stored words
5_00000000_0
6_00000000_0
2_deadbeef_3
2_0badf00d_c
4_00000000_0  // read half was cleared by stop
5_00000000_0
6_00000000_0
3_00000000_0
4_deadbeef_0
4_0badf00d_0
5_00000000_1
6_00000000_0
0_00000000_0
